// ==== source/rv_exec_cfg.svh ====
`ifndef RV_EXEC_CFG_SVH
`define RV_EXEC_CFG_SVH

// datapath
`define XLEN 64

// decoded operation buffer, power of two
`define OP_FIFO_DEPTH 4

// host port
`define AXIL_ADDR_W 12

// register map
`define INST_ADDR   12'h000
`define REG_BASE    12'h400
`define STATUS_ADDR 12'h800

`endif

// ==== source/rv_exec_pkg.sv ====
`include "rv_exec_cfg.svh"

package rv_exec_pkg;

    typedef enum logic [6:0] {
        OP        = 7'b0110011, // add, sub
        OP_IMM    = 7'b0010011, // addi, sltiu, srai
        OP_32     = 7'b0111011, // addw
        OP_IMM_32 = 7'b0011011, // addiw
        LUI       = 7'b0110111,
        SYSTEM    = 7'b1110011  // ebreak only
    } opcode_e;

    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        SLTU   = 3'd2,
        SRA    = 3'd3,
        PASS_B = 3'd4
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } inst_word_u;

    typedef struct packed {
        alu_op_e          alu_op;
        logic             use_imm; // imm replaces rs2
        logic             word_op; // 32-bit result, sign-extended
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
        logic [`XLEN-1:0] imm;
        logic             halt;
    } exec_op_t;

    typedef struct packed {
        logic [5:0]  spare;
        logic [15:0] retired_cnt;
        logic [7:0]  unknown_cnt;
        logic        halted;
        logic        busy;
    } status_t;

endpackage

// ==== source/axil_inst_port.sv ====
`include "rv_exec_cfg.svh"

module axil_inst_port import rv_exec_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`AXIL_ADDR_W-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [`AXIL_ADDR_W-1:0] araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    output inst_word_u              inst,
    output logic                    inst_valid,
    input  logic                    inst_ready,
    input  logic                    unknown_pulse,
    output logic [4:0]              reg_raddr,
    input  logic [`XLEN-1:0]        reg_rdata,
    input  logic                    halted,
    input  logic                    idle,
    input  logic                    fifo_empty,
    input  logic [15:0]             retired_cnt
);

    localparam logic [1:0]  RESP_OKAY   = 2'b00;
    localparam logic [1:0]  RESP_SLVERR = 2'b10;
    localparam int unsigned REG_SPAN    = 32 * 8;

    logic                    aw_inst;
    logic                    wr_fire;
    logic [`AXIL_ADDR_W-1:0] reg_off;
    logic                    rd_pend;
    logic                    rd_reg;
    logic                    rd_hi;
    logic                    rd_status;
    logic [7:0]              unknown_cnt;
    status_t                 status;

    assign aw_inst    = (awaddr == `INST_ADDR) && (wstrb == 4'hf);
    assign inst       = wdata;
    assign inst_valid = awvalid && wvalid && !bvalid && aw_inst;
    assign wr_fire    = awvalid && wvalid && !bvalid && (aw_inst ? inst_ready : 1'b1);
    assign awready    = wr_fire;
    assign wready     = wr_fire;

    assign reg_off   = araddr - `REG_BASE;
    assign reg_raddr = reg_off[7:3]; // 8 bytes per register
    assign arready   = arvalid && !rd_pend && !rvalid;

    always_comb begin
        status             = '0;
        status.busy        = !halted && !(fifo_empty && idle); // halted core never drains
        status.halted      = halted;
        status.unknown_cnt = unknown_cnt;
        status.retired_cnt = retired_cnt;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid      <= 1'b0;
            bresp       <= RESP_OKAY;
            unknown_cnt <= '0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= aw_inst ? RESP_OKAY : RESP_SLVERR;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (unknown_pulse) begin
                unknown_cnt <= unknown_cnt + 8'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend   <= 1'b0;
            rd_reg    <= 1'b0;
            rd_hi     <= 1'b0;
            rd_status <= 1'b0;
            rvalid    <= 1'b0;
            rresp     <= RESP_OKAY;
            rdata     <= '0;
        end else begin
            rd_pend <= arready; // register file answers next cycle
            if (arready) begin
                rd_reg    <= (reg_off < REG_SPAN) && (reg_off[1:0] == 2'b00);
                rd_hi     <= reg_off[2];
                rd_status <= araddr == `STATUS_ADDR;
            end
            if (rd_pend) begin
                rvalid <= 1'b1;
                rresp  <= (rd_reg || rd_status) ? RESP_OKAY : RESP_SLVERR;
                if (rd_reg) begin
                    rdata <= rd_hi ? reg_rdata[`XLEN-1:32] : reg_rdata[31:0];
                end else if (rd_status) begin
                    rdata <= status;
                end else begin
                    rdata <= '0;
                end
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

// ==== source/inst_decoder.sv ====
`include "rv_exec_cfg.svh"

module inst_decoder import rv_exec_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  inst_word_u inst,
    input  logic       inst_valid,
    output logic       inst_ready,
    output exec_op_t   op,
    output logic       op_valid,
    input  logic       op_full,
    output logic       unknown_pulse
);

    opcode_e          opc;
    logic [`XLEN-1:0] i_imm;
    exec_op_t         dec;
    logic             dec_unknown;
    logic             take;

    assign opc        = opcode_e'(inst.r.opcode);
    assign i_imm      = {{(`XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
    assign inst_ready = !op_valid || !op_full; // empty or draining this cycle
    assign take       = inst_valid && inst_ready;

    always_comb begin
        dec         = '0;
        dec_unknown = 1'b0;
        dec.rs1     = inst.r.rs1;
        dec.rs2     = inst.r.rs2;
        dec.rd      = inst.r.rd;
        case (opc)
            OP: begin
                case (inst.r.funct3)
                    3'b000: begin
                        if (inst.r.funct7 == 7'b0000000) begin
                            dec.alu_op = ADD;
                        end else if (inst.r.funct7 == 7'b0100000) begin
                            dec.alu_op = SUB;
                        end else begin
                            dec_unknown = 1'b1;
                        end
                    end
                    default: dec_unknown = 1'b1;
                endcase
            end
            OP_IMM: begin
                dec.use_imm = 1'b1;
                dec.imm     = i_imm;
                case (inst.i.funct3)
                    3'b000: dec.alu_op = ADD;  // addi
                    3'b011: dec.alu_op = SLTU; // sltiu, imm compared unsigned
                    3'b101: begin
                        if (inst.i.imm12[11:6] == 6'b010000) begin // srai only
                            dec.alu_op = SRA;
                            dec.imm    = {{(`XLEN-6){1'b0}}, inst.i.imm12[5:0]};
                        end else begin
                            dec_unknown = 1'b1;
                        end
                    end
                    default: dec_unknown = 1'b1;
                endcase
            end
            OP_32: begin
                dec.word_op = 1'b1;
                if (inst.r.funct3 == 3'b000 && inst.r.funct7 == 7'b0000000) begin
                    dec.alu_op = ADD; // addw
                end else begin
                    dec_unknown = 1'b1;
                end
            end
            OP_IMM_32: begin
                dec.word_op = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = i_imm;
                if (inst.i.funct3 == 3'b000) begin
                    dec.alu_op = ADD; // addiw
                end else begin
                    dec_unknown = 1'b1;
                end
            end
            LUI: begin
                dec.alu_op  = PASS_B;
                dec.use_imm = 1'b1;
                dec.imm     = {{(`XLEN-32){inst.i.imm12[11]}}, inst.i.imm12,
                               inst.i.rs1, inst.i.funct3, 12'b0};
            end
            SYSTEM: begin
                if (inst.i.imm12 == 12'h001 && inst.i.rs1 == 5'd0 &&
                    inst.i.funct3 == 3'b000 && inst.i.rd == 5'd0) begin
                    dec.halt = 1'b1; // ebreak
                end else begin
                    dec_unknown = 1'b1;
                end
            end
            default: dec_unknown = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_valid      <= 1'b0;
            unknown_pulse <= 1'b0;
        end else begin
            unknown_pulse <= take && dec_unknown;
            if (take) begin
                op_valid <= !dec_unknown;
            end else if (!op_full) begin
                op_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && !dec_unknown) begin
            op <= dec;
        end
    end

endmodule

// ==== source/op_fifo.sv ====
`include "rv_exec_cfg.svh"

module op_fifo import rv_exec_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  exec_op_t push_op,
    output logic     full,
    input  logic     pop,
    output exec_op_t head_op,
    output logic     empty
);

    localparam int DEPTH = `OP_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    exec_op_t      mem [DEPTH];
    logic [AW:0]   wr_ptr; // extra bit tells full from empty
    logic [AW:0]   rd_ptr;
    logic          do_push;
    logic          do_pop;

    assign empty   = wr_ptr == rd_ptr;
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head_op = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_op;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== source/int_exec.sv ====
`include "rv_exec_cfg.svh"

module int_exec import rv_exec_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  exec_op_t         head_op,
    input  logic             empty,
    output logic             pop,
    input  logic [4:0]       reg_raddr,
    output logic [`XLEN-1:0] reg_rdata,
    output logic             halted,
    output logic             idle,
    output logic [15:0]      retired_cnt
);

    logic [`XLEN-1:0] rf [32];
    exec_op_t         ex_op;
    logic             ex_valid;
    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] wb_data;

    assign pop   = !empty && !halted;
    assign idle  = !ex_valid;
    assign src_a = rf[ex_op.rs1];
    assign src_b = ex_op.use_imm ? ex_op.imm : rf[ex_op.rs2];

    always_comb begin
        case (ex_op.alu_op)
            ADD:     alu_res = src_a + src_b;
            SUB:     alu_res = src_a - src_b;
            SLTU:    alu_res = {{(`XLEN-1){1'b0}}, src_a < src_b};
            SRA:     alu_res = $signed(src_a) >>> src_b[5:0];
            PASS_B:  alu_res = src_b; // lui
            default: alu_res = '0;
        endcase
    end

    assign wb_data = ex_op.word_op ? {{(`XLEN-32){alu_res[31]}}, alu_res[31:0]} : alu_res;

    always_ff @(posedge clk) begin
        if (pop) begin
            ex_op <= head_op;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid    <= 1'b0;
            halted      <= 1'b0;
            retired_cnt <= '0;
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else begin
            ex_valid <= pop;
            if (pop && head_op.halt) begin
                halted <= 1'b1; // stops the next pop already
            end
            if (ex_valid) begin
                retired_cnt <= retired_cnt + 16'd1;
                if (ex_op.rd != 5'd0) begin
                    rf[ex_op.rd] <= wb_data;
                end
            end
        end
    end

    // host read port
    always_ff @(posedge clk) begin
        reg_rdata <= rf[reg_raddr];
    end

endmodule

// ==== source/rv_exec_top.sv ====
`include "rv_exec_cfg.svh"

module rv_exec_top import rv_exec_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`AXIL_ADDR_W-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [`AXIL_ADDR_W-1:0] araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready
);

    inst_word_u       inst;
    logic             inst_valid;
    logic             inst_ready;
    logic             unknown_pulse;
    exec_op_t         op;
    logic             op_valid;
    logic             fifo_push;
    logic             fifo_full;
    exec_op_t         head_op;
    logic             fifo_empty;
    logic             fifo_pop;
    logic [4:0]       reg_raddr;
    logic [`XLEN-1:0] reg_rdata;
    logic             halted;
    logic             idle;
    logic [15:0]      retired_cnt;

    assign fifo_push = op_valid && !fifo_full;

    axil_inst_port u_port (.*);

    inst_decoder u_dec (.*, .op_full(fifo_full));

    op_fifo u_fifo (
        .*,
        .push    (fifo_push),
        .push_op (op),
        .full    (fifo_full),
        .pop     (fifo_pop),
        .empty   (fifo_empty)
    );

    int_exec u_exec (.*, .empty(fifo_empty), .pop(fifo_pop));

endmodule

// ==== verif/tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int HALF_PERIOD = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk; // 40-unit period
    end

endmodule

// ==== verif/rv_exec_asserts.sv ====
`include "rv_exec_cfg.svh"

module rv_exec_asserts import rv_exec_pkg::*; (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            full,
    input logic                            empty,
    input logic [$clog2(`OP_FIFO_DEPTH):0] wr_ptr,
    input logic [$clog2(`OP_FIFO_DEPTH):0] rd_ptr,
    input exec_op_t                        push_op,
    input logic                            op_valid
);

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        full |=> wr_ptr == $past(wr_ptr))
        else $error("op_fifo pushed while full");

    no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        empty |=> rd_ptr == $past(rd_ptr))
        else $error("op_fifo popped while empty");

    // decoder must not overwrite a waiting op
    held_while_full: assert property (@(posedge clk) disable iff (!rst_n)
        op_valid && full |=> $stable(push_op))
        else $error("decoder output changed while op_fifo full");

endmodule

// ==== verif/rv_exec_tb.sv ====
`include "rv_exec_cfg.svh"

module rv_exec_tb import rv_exec_pkg::*; ();

    localparam int         TIMEOUT     = 500;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic                    clk;
    logic                    rst_n;
    logic [`AXIL_ADDR_W-1:0] awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [31:0]             wdata;
    logic [3:0]              wstrb;
    logic                    wvalid;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;
    logic [`AXIL_ADDR_W-1:0] araddr;
    logic                    arvalid;
    logic                    arready;
    logic [31:0]             rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready;

    logic [`XLEN-1:0] ref_rf [32]; // reference register file
    logic [15:0]      exp_retired;
    logic [7:0]       exp_unknown;
    logic             exp_halted;
    logic [31:0]      lcg_state;

    tb_clk_gen u_clk (.clk(clk));

    rv_exec_top uut (.*);

    bind op_fifo rv_exec_asserts u_fifo_asserts (
        .clk      (clk),
        .rst_n    (rst_n),
        .full     (full),
        .empty    (empty),
        .wr_ptr   (wr_ptr),
        .rd_ptr   (rd_ptr),
        .push_op  (push_op),
        .op_valid (u_dec.op_valid)
    );

    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [63:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s at time %0t", what, $time);
        stop_run();
    endtask

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int n;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        #1;
        while (!awready) begin // decoder may hold off
            n++;
            if (n > TIMEOUT) report_timeout("awready");
            @(negedge clk);
            #1;
        end
        check_eq(wready, 1'b1, "wready with awready");
        @(posedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        n = 0;
        while (!bvalid) begin
            n++;
            if (n > TIMEOUT) report_timeout("bvalid");
            @(negedge clk);
        end
        resp = bresp;
        @(posedge clk);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        #1;
        while (!arready) begin
            n++;
            if (n > TIMEOUT) report_timeout("arready");
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        n = 0;
        while (!rvalid) begin
            n++;
            if (n > TIMEOUT) report_timeout("rvalid");
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic issue(input logic [31:0] word);
        logic [1:0] resp;
        axil_write(`INST_ADDR, word, resp);
        check_eq(resp, RESP_OKAY, "instruction write bresp");
    endtask

    task automatic read_status(output status_t s);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(`STATUS_ADDR, data, resp);
        check_eq(resp, RESP_OKAY, "status rresp");
        s = status_t'(data);
    endtask

    task automatic wait_idle();
        status_t s;
        int      n;
        n = 0;
        read_status(s);
        while (s.busy) begin
            n++;
            if (n > TIMEOUT) report_timeout("busy to clear");
            read_status(s);
        end
    endtask

    // registers first, then counters, so a late retire is seen
    task automatic check_regs();
        logic [31:0] lo;
        logic [31:0] hi;
        logic [1:0]  resp;
        status_t     s;
        wait_idle();
        for (int i = 0; i < 32; i++) begin
            axil_read(`REG_BASE + 12'(8 * i), lo, resp);
            check_eq(resp, RESP_OKAY, $sformatf("x%0d low rresp", i));
            axil_read(`REG_BASE + 12'(8 * i + 4), hi, resp);
            check_eq(resp, RESP_OKAY, $sformatf("x%0d high rresp", i));
            check_eq({hi, lo}, ref_rf[i], $sformatf("x%0d", i));
        end
        read_status(s);
        check_eq(s.retired_cnt, exp_retired, "retired_cnt");
        check_eq(s.unknown_cnt, exp_unknown, "unknown_cnt");
        check_eq(s.halted, exp_halted, "halted");
        check_eq(s.spare, 6'd0, "status spare bits");
    endtask

    // encode one instruction and apply it to the model
    task automatic run_op(input string name, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [31:0] x);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic [31:0] word;
        a = ref_rf[rs1];
        b = ref_rf[x[4:0]];
        case (name)
            "add": begin
                word = {7'h00, x[4:0], rs1, 3'b000, rd, 7'b0110011};
                r    = a + b;
            end
            "sub": begin
                word = {7'h20, x[4:0], rs1, 3'b000, rd, 7'b0110011};
                r    = a - b;
            end
            "addw": begin
                word = {7'h00, x[4:0], rs1, 3'b000, rd, 7'b0111011};
                r    = sext32(a[31:0] + b[31:0]);
            end
            "addi": begin
                word = {x[11:0], rs1, 3'b000, rd, 7'b0010011};
                r    = a + sext12(x[11:0]);
            end
            "sltiu": begin
                word = {x[11:0], rs1, 3'b011, rd, 7'b0010011};
                r    = (a < sext12(x[11:0])) ? 64'd1 : 64'd0;
            end
            "srai": begin
                word = {6'b010000, x[5:0], rs1, 3'b101, rd, 7'b0010011};
                r    = $signed(a) >>> x[5:0];
            end
            "addiw": begin
                word = {x[11:0], rs1, 3'b000, rd, 7'b0011011};
                r    = sext32(a[31:0] + x[11:0] + {{20{x[11]}}, 12'h000});
            end
            "lui": begin
                word = {x[19:0], rd, 7'b0110111};
                r    = sext32({x[19:0], 12'h000});
            end
            default: begin
                $display("testbench asked for an instruction it cannot encode: %s", name);
                stop_run();
            end
        endcase
        issue(word);
        if (rd != 5'd0) begin
            ref_rf[rd] = r;
        end
        exp_retired++;
    endtask

    task automatic test_reset_state();
        status_t s;
        read_status(s);
        check_eq(s, 32'd0, "status after reset");
        check_regs();
    endtask

    task automatic test_alu_ops();
        for (int i = 1; i < 8; i++) begin
            run_op("addi", 5'(i), 5'd0, rand32());
        end
        run_op("add", 5'd8, 5'd1, 32'd2);
        run_op("add", 5'd8, 5'd8, 32'd8); // grow past 12 bits
        run_op("sub", 5'd9, 5'd3, 32'd4);
        run_op("sltiu", 5'd10, 5'd5, rand32());
        run_op("sltiu", 5'd11, 5'd0, 32'h001);
        run_op("srai", 5'd12, 5'd6, rand32());
        run_op("srai", 5'd13, 5'd9, rand32());
        run_op("add", 5'd0, 5'd1, 32'd2); // x0 stays zero
        check_regs();
    endtask

    task automatic test_word_ops();
        logic [31:0] r;
        r = rand32();
        run_op("lui", 5'd14, 5'd0, {12'h000, 1'b1, r[18:0]});
        run_op("lui", 5'd15, 5'd0, 32'h7ffff);
        run_op("addw", 5'd16, 5'd15, 32'd15);
        run_op("addw", 5'd17, 5'd14, 32'd14);
        run_op("addi", 5'd18, 5'd15, 32'h7ff);
        run_op("addiw", 5'd19, 5'd18, 32'h7ff);
        run_op("addw", 5'd20, 5'd1, 32'd2);
        run_op("addiw", 5'd21, 5'd14, rand32());
        check_regs();
    endtask

    task automatic test_backpressure();
        for (int i = 0; i < `OP_FIFO_DEPTH + 6; i++) begin
            run_op("addi", 5'(22 + i % 4), 5'(22 + (i + 3) % 4), rand32());
        end
        check_regs();
    endtask

    task automatic test_unknown_and_bad_addr();
        logic [31:0] r;
        logic [31:0] data;
        logic [1:0]  resp;
        r = rand32();
        issue({r[31:7], 7'b0100011}); // sw
        r = rand32();
        issue({r[31:7], 7'b1100011}); // beq family
        issue({7'h00, 5'd2, 5'd1, 3'b001, 5'd26, 7'b0110011}); // sll not supported
        exp_unknown = exp_unknown + 8'd3;
        axil_write(12'h004, 32'h0000_0013, resp);
        check_eq(resp, RESP_SLVERR, "unmapped write bresp");
        axil_read(12'hc00, data, resp);
        check_eq(resp, RESP_SLVERR, "unmapped read rresp");
        check_eq(data, 32'd0, "unmapped read data");
        check_regs();
    endtask

    task automatic test_ebreak();
        issue(32'h0010_0073);
        exp_retired++;
        exp_halted = 1'b1;
        // queued behind the halt until the FIFO and decoder register are full
        for (int i = 0; i <= `OP_FIFO_DEPTH; i++) begin
            issue({12'h123, 5'd0, 3'b000, 5'(1 + i), 7'b0010011});
        end
        check_regs();
    endtask

    initial begin
        rst_n       = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = 4'hf;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        lcg_state   = 32'h60e1;
        exp_retired = '0;
        exp_unknown = '0;
        exp_halted  = 1'b0;
        for (int i = 0; i < 32; i++) begin
            ref_rf[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_alu_ops();
        test_word_ops();
        test_backpressure();
        test_unknown_and_bad_addr();
        test_ebreak();

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== rv_exec.f ====
+incdir+source
source/rv_exec_pkg.sv
source/axil_inst_port.sv
source/inst_decoder.sv
source/op_fifo.sv
source/int_exec.sv
source/rv_exec_top.sv
verif/tb_clk_gen.sv
verif/rv_exec_asserts.sv
verif/rv_exec_tb.sv

// ==== Bender.yml ====
package:
  name: rv_exec

sources:
  - include_dirs:
      - source
    files:
      - source/rv_exec_pkg.sv
      - source/axil_inst_port.sv
      - source/inst_decoder.sv
      - source/op_fifo.sv
      - source/int_exec.sv
      - source/rv_exec_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_clk_gen.sv
      - verif/rv_exec_asserts.sv
      - verif/rv_exec_tb.sv
